/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation ended early"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cache_ctrl.sv */
module cache_ctrl #(
    parameter int  sets    = 128,
    localparam int index_w = $clog2(sets),
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w,
    localparam int mask_w  = cache_pkg::line_w / 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_i,
    input  cache_pkg::cache_op_e         op_i,
    input  logic [cache_pkg::addr_w-1:0] addr_i,
    input  logic [cache_pkg::word_w-1:0] wdata_i,
    input  logic [cache_pkg::strb_w-1:0] wstrb_i,
    input  logic                         hit_i,
    input  logic                         hit_way_i,
    input  logic                         victim_way_i,
    input  logic                         victim_dirty_i,
    input  logic [tag_w-1:0]             victim_tag_i,
    input  logic [cache_pkg::line_w-1:0] line0_i,
    input  logic [cache_pkg::line_w-1:0] line1_i,
    input  logic                         wr_ready_i,
    input  logic                         rd_ready_i,
    input  logic [cache_pkg::word_w-1:0] rdata_i,
    input  logic                         rvalid_i,
    input  logic                         rlast_i,
    output logic                         ready_o,
    output logic                         valid_o,
    output logic [cache_pkg::word_w-1:0] rdata_o,
    output logic [index_w-1:0]           tag_index_o,
    output logic [tag_w-1:0]             tag_o,
    output logic                         tag_wr_en_o,
    output logic                         tag_wr_way_o,
    output logic                         tag_wr_dirty_o,
    output logic                         touch_o,
    output logic                         touch_way_o,
    output logic                         data_wr_en_o,
    output logic                         data_wr_way_o,
    output logic [index_w-1:0]           data_wr_index_o,
    output logic [cache_pkg::line_w-1:0] data_wr_data_o,
    output logic [mask_w-1:0]            data_wr_mask_o,
    output logic [index_w-1:0]           data_rd_index_o,
    output logic                         wr_req_o,
    output logic [cache_pkg::addr_w-1:0] wr_addr_o,
    output logic [cache_pkg::line_w-1:0] wr_data_o,
    output logic                         rd_req_o,
    output logic [cache_pkg::addr_w-1:0] rd_addr_o
);
    import cache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;

    // request buffer, loaded on accept
    logic [addr_w-1:0] addr_r;
    cache_op_e         op_r;
    logic [word_w-1:0] wdata_r;
    logic [strb_w-1:0] wstrb_r;
    logic              hit_way_r;
    logic              victim_way_r;
    logic [tag_w-1:0]  victim_tag_r;
    logic [word_w-1:0] hit_word_r;  // addressed word of the hit line

    logic [line_w-1:0] fill_line;   // refill beats land here
    logic              beat;

    logic               accept;
    logic               is_write;
    logic [index_w-1:0] index_r;
    logic [2:0]         byte_off;
    logic [line_w-1:0]  hit_line;
    logic [word_w-1:0]  wdata_sh;
    logic [strb_w-1:0]  wstrb_sh;
    logic [line_w-1:0]  wline;
    logic [mask_w-1:0]  wmask;
    logic [line_w-1:0]  merged_line;
    logic [word_w-1:0]  resp_word;

    assign accept   = req_i && ready_o;
    assign is_write = (op_r == op_write);
    assign index_r  = addr_r[offset_w +: index_w];
    assign byte_off = addr_r[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle, s_lookup: begin
                if (accept) begin
                    if (hit_i) begin
                        state_next = s_lookup;
                    end else if (victim_dirty_i) begin
                        state_next = s_writeback;
                    end else begin
                        state_next = s_refill_req;
                    end
                end else begin
                    state_next = s_idle;  // also after a write hit
                end
            end
            s_writeback: begin
                if (wr_ready_i) begin
                    state_next = s_refill_req;
                end
            end
            s_refill_req: begin
                if (rd_ready_i) begin
                    state_next = s_refill_data;
                end
            end
            s_refill_data: begin
                if (rvalid_i && rlast_i) begin
                    state_next = s_refill;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    // line read at the incoming index during idle and lookup
    assign hit_line = hit_way_i ? line1_i : line0_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_r       <= addr_i;
            op_r         <= op_i;
            wdata_r      <= wdata_i;
            wstrb_r      <= wstrb_i;
            hit_way_r    <= hit_way_i;
            victim_way_r <= victim_way_i;
            victim_tag_r <= victim_tag_i;
            hit_word_r   <= addr_i[offset_w-1] ? hit_line[line_w-1:word_w]
                                               : hit_line[word_w-1:0];
        end
    end

    // two beats, low word first
    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= 1'b0;
        end else if (rd_req_o && rd_ready_i) begin
            beat <= 1'b0;
        end else if (state == s_refill_data && rvalid_i) begin
            beat <= ~beat;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_refill_data && rvalid_i) begin
            fill_line[int'(beat)*word_w +: word_w] <= rdata_i;
        end
    end

    // store data and strobe moved to their byte lanes
    assign wdata_sh = wdata_r << {byte_off, 3'b000};
    assign wstrb_sh = wstrb_r << byte_off;
    assign wline    = {wdata_sh, wdata_sh};
    assign wmask    = addr_r[offset_w-1] ? {wstrb_sh, {strb_w{1'b0}}}
                                         : {{strb_w{1'b0}}, wstrb_sh};

    // write miss bytes over the refilled line
    always_comb begin
        for (int b = 0; b < mask_w; b++) begin
            if (is_write && wmask[b]) begin
                merged_line[b*8 +: 8] = wline[b*8 +: 8];
            end else begin
                merged_line[b*8 +: 8] = fill_line[b*8 +: 8];
            end
        end
    end

    always_comb begin
        if (state == s_refill) begin
            resp_word = addr_r[offset_w-1] ? merged_line[line_w-1:word_w]
                                           : merged_line[word_w-1:0];
        end else begin
            resp_word = hit_word_r;
        end
    end

    assign rdata_o = resp_word >> {byte_off, 3'b000};
    assign valid_o = (state == s_lookup) || (state == s_refill);
    assign ready_o = (state == s_idle) || (state == s_lookup && !is_write);

    // tag side
    assign tag_index_o    = index_r;
    assign tag_o          = addr_r[addr_w-1 -: tag_w];
    assign tag_wr_en_o    = (state == s_lookup && is_write) || (state == s_refill);
    assign tag_wr_way_o   = (state == s_refill) ? victim_way_r : hit_way_r;
    assign tag_wr_dirty_o = is_write;
    assign touch_o        = accept;
    assign touch_way_o    = hit_i ? hit_way_i : victim_way_i;

    // data side
    assign data_wr_en_o    = tag_wr_en_o;
    assign data_wr_way_o   = tag_wr_way_o;
    assign data_wr_index_o = index_r;
    assign data_wr_data_o  = (state == s_refill) ? merged_line : wline;
    assign data_wr_mask_o  = (state == s_refill) ? {mask_w{1'b1}} : wmask;
    assign data_rd_index_o = (state == s_writeback) ? index_r : addr_i[offset_w +: index_w];

    // memory ports, line aligned
    assign wr_req_o  = (state == s_writeback);
    assign wr_addr_o = {victim_tag_r, index_r, {offset_w{1'b0}}};
    assign wr_data_o = victim_way_r ? line1_i : line0_i;
    assign rd_req_o  = (state == s_refill_req);
    assign rd_addr_o = {addr_r[addr_w-1:offset_w], {offset_w{1'b0}}};

endmodule

/* cache_pkg.sv */
package cache_pkg;

    localparam int addr_w   = 32;
    localparam int word_w   = 64;
    localparam int strb_w   = 8;
    localparam int line_w   = 128;  // 16 bytes
    localparam int offset_w = 4;    // bit 3 picks the word in a line
    localparam int ways     = 2;    // victim rule is written for two

    // access type from the load/store unit
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_e;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,       // hit response
        s_writeback,    // dirty victim out
        s_refill_req,
        s_refill_data,  // gathering beats
        s_refill        // line and tag update
    } cache_state_e;

endpackage

/* data_store.sv */
module data_store #(
    parameter int  sets    = 128,
    localparam int index_w = $clog2(sets),
    localparam int mask_w  = cache_pkg::line_w / 8
) (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  logic                        wr_way_i,
    input  logic [index_w-1:0]          wr_index_i,
    input  logic [cache_pkg::line_w-1:0] wr_data_i,
    input  logic [mask_w-1:0]           wr_mask_i,
    input  logic [index_w-1:0]          rd_index_i,
    output logic [cache_pkg::line_w-1:0] rd_line0_o,
    output logic [cache_pkg::line_w-1:0] rd_line1_o
);
    import cache_pkg::*;

    logic [line_w-1:0] lines [ways][sets];

    // byte-masked write of one way
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < mask_w; b++) begin
                if (wr_mask_i[b]) begin
                    lines[wr_way_i][wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // both ways of one set, same cycle
    assign rd_line0_o = lines[0][rd_index_i];
    assign rd_line1_o = lines[1][rd_index_i];

endmodule

/* dcache.sv */
module dcache #(
    parameter int  sets    = 128,
    localparam int index_w = $clog2(sets),
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w,
    localparam int mask_w  = cache_pkg::line_w / 8
) (
    input  logic                         clk,
    input  logic                         rst,
    // load/store unit
    input  logic                         req_i,
    input  cache_pkg::cache_op_e         op_i,
    input  logic [cache_pkg::addr_w-1:0] addr_i,
    input  logic [cache_pkg::word_w-1:0] wdata_i,
    input  logic [cache_pkg::strb_w-1:0] wstrb_i,
    output logic                         ready_o,
    output logic                         valid_o,
    output logic [cache_pkg::word_w-1:0] rdata_o,
    // memory write port
    output logic                         wr_req_o,
    output logic [cache_pkg::addr_w-1:0] wr_addr_o,
    output logic [cache_pkg::line_w-1:0] wr_data_o,
    input  logic                         wr_ready_i,
    // memory read port
    output logic                         rd_req_o,
    output logic [cache_pkg::addr_w-1:0] rd_addr_o,
    input  logic                         rd_ready_i,
    input  logic [cache_pkg::word_w-1:0] rdata_i,
    input  logic                         rvalid_i,
    input  logic                         rlast_i
);
    import cache_pkg::*;

    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic [tag_w-1:0]   victim_tag;
    logic [index_w-1:0] tag_wr_index;
    logic [tag_w-1:0]   tag_wr_tag;
    logic               tag_wr_en;
    logic               tag_wr_way;
    logic               tag_wr_dirty;
    logic               touch;
    logic               touch_way;
    logic               data_wr_en;
    logic               data_wr_way;
    logic [index_w-1:0] data_wr_index;
    logic [line_w-1:0]  data_wr_data;
    logic [mask_w-1:0]  data_wr_mask;
    logic [index_w-1:0] data_rd_index;
    logic [line_w-1:0]  line0;
    logic [line_w-1:0]  line1;

    // lookup runs on the incoming address
    tag_store #(.sets(sets)) tag_store_inst (
        .clk            (clk),
        .rst            (rst),
        .index_i        (addr_i[offset_w +: index_w]),
        .tag_i          (addr_i[addr_w-1 -: tag_w]),
        .wr_en_i        (tag_wr_en),
        .wr_way_i       (tag_wr_way),
        .wr_index_i     (tag_wr_index),
        .wr_tag_i       (tag_wr_tag),
        .wr_dirty_i     (tag_wr_dirty),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    data_store #(.sets(sets)) data_store_inst (
        .clk        (clk),
        .wr_en_i    (data_wr_en),
        .wr_way_i   (data_wr_way),
        .wr_index_i (data_wr_index),
        .wr_data_i  (data_wr_data),
        .wr_mask_i  (data_wr_mask),
        .rd_index_i (data_rd_index),
        .rd_line0_o (line0),
        .rd_line1_o (line1)
    );

    cache_ctrl #(.sets(sets)) cache_ctrl_inst (
        .clk             (clk),
        .rst             (rst),
        .req_i           (req_i),
        .op_i            (op_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .wstrb_i         (wstrb_i),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .line0_i         (line0),
        .line1_i         (line1),
        .wr_ready_i      (wr_ready_i),
        .rd_ready_i      (rd_ready_i),
        .rdata_i         (rdata_i),
        .rvalid_i        (rvalid_i),
        .rlast_i         (rlast_i),
        .ready_o         (ready_o),
        .valid_o         (valid_o),
        .rdata_o         (rdata_o),
        .tag_index_o     (tag_wr_index),
        .tag_o           (tag_wr_tag),
        .tag_wr_en_o     (tag_wr_en),
        .tag_wr_way_o    (tag_wr_way),
        .tag_wr_dirty_o  (tag_wr_dirty),
        .touch_o         (touch),
        .touch_way_o     (touch_way),
        .data_wr_en_o    (data_wr_en),
        .data_wr_way_o   (data_wr_way),
        .data_wr_index_o (data_wr_index),
        .data_wr_data_o  (data_wr_data),
        .data_wr_mask_o  (data_wr_mask),
        .data_rd_index_o (data_rd_index),
        .wr_req_o        (wr_req_o),
        .wr_addr_o       (wr_addr_o),
        .wr_data_o       (wr_data_o),
        .rd_req_o        (rd_req_o),
        .rd_addr_o       (rd_addr_o)
    );

endmodule

/* dcache_tb.sv */
module dcache_tb;
    import cache_pkg::*;

    localparam int n_ops         = 400;
    localparam int lines         = 16;  // 4 tags x 4 sets
    localparam int watchdog_time = n_ops * 40 * 100;

    logic              clk;
    logic              rst;
    logic              req;
    cache_op_e         op;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              ready;
    logic              valid;
    logic [word_w-1:0] rdata;
    logic              wr_req;
    logic [addr_w-1:0] wr_addr;
    logic [line_w-1:0] wr_data;
    logic              wr_ready;
    logic              rd_req;
    logic [addr_w-1:0] rd_addr;
    logic              rd_ready;
    logic [word_w-1:0] beat_data;
    logic              rvalid;
    logic              rlast;

    logic [31:0]       lfsr;
    logic [line_w-1:0] mem_line [lines];  // backing memory
    logic [line_w-1:0] ref_line [lines];  // every write applied
    logic              m_valid  [4][2];
    logic [1:0]        m_tag    [4][2];
    logic              m_dirty  [4][2];
    logic              m_recent [4];
    int                errors;
    int                tests_ok;

    tb_clock #(.period(100)) tb_clock_inst (.clk_o(clk));

    dcache dcache_inst (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req),
        .op_i       (op),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .wstrb_i    (wstrb),
        .ready_o    (ready),
        .valid_o    (valid),
        .rdata_o    (rdata),
        .wr_req_o   (wr_req),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_ready_i (wr_ready),
        .rd_req_o   (rd_req),
        .rd_addr_o  (rd_addr),
        .rd_ready_i (rd_ready),
        .rdata_i    (beat_data),
        .rvalid_i   (rvalid),
        .rlast_i    (rlast)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [addr_w-1:0] line_addr(input logic [3:0] ln);
        return {19'b0, ln[3:2], 5'b0, ln[1:0], 4'b0};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;  // inputs change well after the edge
    endtask

    task automatic value_error(input string name, input logic [line_w-1:0] got,
                               input logic [line_w-1:0] exp);
        $display("Error: %s is %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    // memory latency of 0 to 3 cycles
    task automatic memory_delay();
        logic [1:0] d;
        d = 2'(take_bits(2));
        repeat (int'(d)) next_cycle();
    endtask

    task automatic do_access(input int n);
        logic              is_wr;
        logic [1:0]        tag;
        logic [1:0]        set;
        logic [3:0]        off;
        logic [3:0]        ln;
        logic [3:0]        vln;
        logic              hit;
        logic              hway;
        logic              vway;
        logic              vdirty;
        logic [word_w-1:0] exp_word;
        int                err_before;
        int                pos;

        is_wr = 1'(take_bits(1));
        tag   = 2'(take_bits(2));
        set   = 2'(take_bits(2));
        off   = 4'(take_bits(4));
        ln    = {tag, set};
        err_before = errors;

        // model lookup and victim
        hit  = 1'b0;
        hway = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit  = 1'b1;
                hway = w[0];
            end
        end
        if (!m_valid[set][0]) begin
            vway = 1'b0;
        end else if (!m_valid[set][1]) begin
            vway = 1'b1;
        end else begin
            vway = ~m_recent[set];
        end
        vdirty   = m_valid[set][vway] && m_dirty[set][vway];
        vln      = {m_tag[set][vway], set};
        exp_word = ref_line[ln][int'(off[3]) * 64 +: 64] >> (8 * int'(off[2:0]));

        while (!ready) next_cycle();
        req   = 1'b1;
        op    = cache_op_e'(is_wr);
        addr  = {19'b0, tag, 5'b0, set, off};
        wdata = take_bits(64);
        wstrb = 8'(take_bits(8));
        next_cycle();
        req = 1'b0;

        if (hit) begin
            if (!valid) report_problem("hit response did not arrive one cycle after acceptance");
            if (ready !== !is_wr) value_error("ready_o", line_w'(ready), line_w'(!is_wr));
            if (wr_req || rd_req) report_problem("memory request seen on a predicted hit");
        end else begin
            if (valid) report_problem("early response on a predicted miss");
            if (ready !== 1'b0) value_error("ready_o", line_w'(ready), '0);
            if (wr_req !== vdirty) value_error("wr_req_o", line_w'(wr_req), line_w'(vdirty));
            if (wr_req) begin
                if (wr_addr !== line_addr(vln)) begin
                    value_error("wr_addr_o", line_w'(wr_addr), line_w'(line_addr(vln)));
                end
                if (wr_data !== ref_line[vln]) value_error("wr_data_o", wr_data, ref_line[vln]);
                memory_delay();
                wr_ready = 1'b1;
                mem_line[vln] = wr_data;
                next_cycle();
                wr_ready = 1'b0;
            end
            while (!rd_req) next_cycle();
            if (rd_addr !== line_addr(ln)) begin
                value_error("rd_addr_o", line_w'(rd_addr), line_w'(line_addr(ln)));
            end
            memory_delay();
            rd_ready = 1'b1;
            next_cycle();
            rd_ready = 1'b0;
            for (int b = 0; b < 2; b++) begin  // low word first
                memory_delay();
                rvalid    = 1'b1;
                rlast     = (b == 1);
                beat_data = mem_line[ln][b * 64 +: 64];
                next_cycle();
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
            if (!valid) report_problem("no response in the cycle after the last refill beat");
        end
        if (!is_wr && valid && rdata !== exp_word) begin
            value_error("rdata_o", line_w'(rdata), line_w'(exp_word));
        end

        if (is_wr) begin
            // strobe and data shifted by the byte offset with the overflow dropped
            for (int k = 0; k < 8; k++) begin
                pos = int'(off[2:0]) + k;
                if (pos < 8 && wstrb[k]) begin
                    ref_line[ln][(int'(off[3]) * 8 + pos) * 8 +: 8] = wdata[k * 8 +: 8];
                end
            end
        end
        if (hit) begin
            m_recent[set] = hway;
            if (is_wr) m_dirty[set][hway] = 1'b1;
        end else begin
            m_valid[set][vway] = 1'b1;
            m_tag[set][vway]   = tag;
            m_dirty[set][vway] = is_wr;
            m_recent[set]      = vway;
        end

        if (errors == err_before) tests_ok++;
        $display("test %0d: %s addr %h %s %s", n, is_wr ? "write" : "read ", addr,
                 hit ? "hit " : "miss", (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        #(watchdog_time);
        $display("watchdog: run did not finish within %0d time units", watchdog_time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        op        = op_read;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        wr_ready  = 1'b0;
        rd_ready  = 1'b0;
        beat_data = '0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        errors    = 0;
        tests_ok  = 0;
        lfsr      = 32'h7460_c645;
        for (int i = 0; i < lines; i++) begin
            mem_line[i] = {take_bits(64), take_bits(64)};
            ref_line[i] = mem_line[i];
        end
        for (int s = 0; s < 4; s++) begin
            m_recent[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = 2'b0;
                m_dirty[s][w] = 1'b0;
            end
        end

        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();
        if (ready !== 1'b1) value_error("ready_o", line_w'(ready), line_w'(1'b1));
        if (valid !== 1'b0) value_error("valid_o", line_w'(valid), '0);
        if (rd_req !== 1'b0) value_error("rd_req_o", line_w'(rd_req), '0);
        if (wr_req !== 1'b0) value_error("wr_req_o", line_w'(wr_req), '0);
        if (errors == 0) tests_ok++;
        $display("test 0: reset state %s", (errors == 0) ? "ok" : "failed");

        for (int n = 1; n <= n_ops; n++) begin
            do_access(n);
        end

        $display("tests passed: %0d of %0d, errors: %0d", tests_ok, n_ops + 1, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
cache_pkg.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
dcache.sv
tb_clock.sv
dcache_tb.sv

/* tag_store.sv */
module tag_store #(
    parameter int  sets    = 128,
    localparam int index_w = $clog2(sets),
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [index_w-1:0] index_i,
    input  logic [tag_w-1:0]   tag_i,
    input  logic               wr_en_i,
    input  logic               wr_way_i,
    input  logic [index_w-1:0] wr_index_i,
    input  logic [tag_w-1:0]   wr_tag_i,
    input  logic               wr_dirty_i,
    input  logic               touch_i,
    input  logic               touch_way_i,
    output logic               hit_o,
    output logic               hit_way_o,
    output logic               victim_way_o,
    output logic               victim_dirty_o,
    output logic [tag_w-1:0]   victim_tag_o
);
    import cache_pkg::*;

    logic [tag_w-1:0] tags  [ways][sets];
    logic [sets-1:0]  valid [ways];
    logic [sets-1:0]  dirty [ways];
    logic [sets-1:0]  recent;  // way touched last, per set

    logic [ways-1:0] way_valid;
    logic [ways-1:0] way_hit;

    // compare both ways of the incoming set
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_valid[w] = valid[w][index_i];
            way_hit[w]   = way_valid[w] && (tags[w][index_i] == tag_i);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid way first, else the one not used last
    always_comb begin
        if (!way_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~recent[index_i];
        end
    end

    assign victim_dirty_o = way_valid[victim_way_o] && dirty[victim_way_o][index_i];
    assign victim_tag_o   = tags[victim_way_o][index_i];  // for the write-back address

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < ways; w++) begin
                valid[w] <= '0;
            end
            recent <= '0;
        end else begin
            if (wr_en_i) begin
                valid[wr_way_i][wr_index_i] <= 1'b1;  // any write fills the way
            end
            if (touch_i) begin
                recent[index_i] <= touch_way_i;
            end
        end
    end

    // tag and dirty only mean something under valid
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags[wr_way_i][wr_index_i]  <= wr_tag_i;
            dirty[wr_way_i][wr_index_i] <= wr_dirty_i;
        end
    end

endmodule

/* tb_clock.sv */
module tb_clock #(
    parameter int period = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period / 2) clk_o = ~clk_o;
        end
    end

endmodule
